//--- uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// clk_16bd cycles per serial bit
`define UART_OVERSAMPLE 16

// sample index inside a bit where the line is read
`define UART_MID_SAMPLE 8

// widest data word, frames carry 5 to 9 bits
`define UART_DATA_W 9

`endif

//--- uart_pkg.sv
`include "uart_cfg.svh"
`default_nettype none

package uart_pkg;

    // frame settings shared by both directions
    typedef struct packed {
        logic       parity_en;
        logic       parity_odd;
        logic       two_stop;
        // 5 to 9
        logic [3:0] data_bits;
    } frame_cfg_t;

    // one received frame, pulses last a single cycle
    typedef struct packed {
        // lsb first on the line, unused upper bits zero
        logic [`UART_DATA_W-1:0] data;
        logic                    valid;
        logic                    error;
    } rx_result_t;

endpackage

`default_nettype wire

//--- uart_tx_frame.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"
`default_nettype none

module uart_tx_frame (
    input  wire logic                    clk_16bd,
    input  wire logic                    rst,
    input  wire uart_pkg::frame_cfg_t    cfg,
    input  wire logic [`UART_DATA_W-1:0] tx_data,
    input  wire logic                    tx_start,
    output logic                         tx,
    output logic                         tx_busy
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_OVERSAMPLE);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`UART_OVERSAMPLE - 1);

    typedef enum logic [2:0] {
        T_IDLE,
        T_START,
        T_DATA,
        T_PARITY,
        T_STOP
    } tx_state_t;

    tx_state_t state;

    logic [CNT_W-1:0] timer;
    logic [3:0] bit_cnt;
    logic stop_cnt;
    logic bit_end;
    logic accept;

    frame_cfg_t cfg_q;
    logic [`UART_DATA_W-1:0] shift_q;
    logic par_q;
    logic [`UART_DATA_W-1:0] data_mask;

    assign accept = (state == T_IDLE) && tx_start;
    assign bit_end = (timer == LAST);
    assign tx_busy = (state != T_IDLE);

    // only the low data_bits count toward parity
    assign data_mask = ~({`UART_DATA_W{1'b1}} << cfg.data_bits);

    always_ff @(posedge clk_16bd) begin
        if (accept) begin
            cfg_q <= cfg;
            shift_q <= tx_data;
            par_q <= ^(tx_data & data_mask) ^ cfg.parity_odd;
        end else if (state == T_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk_16bd or negedge rst) begin
        if (!rst) begin
            state <= T_IDLE;
            tx <= 1'b1;
            timer <= '0;
            bit_cnt <= '0;
            stop_cnt <= 1'b0;
        end else begin
            if (state == T_IDLE || bit_end) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end

            case (state)
                T_IDLE: begin
                    if (tx_start) begin
                        state <= T_START;
                        tx <= 1'b0;
                        bit_cnt <= '0;
                    end
                end

                T_START: begin
                    if (bit_end) begin
                        state <= T_DATA;
                        tx <= shift_q[0];
                    end
                end

                T_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == cfg_q.data_bits - 4'd1) begin
                            stop_cnt <= 1'b0;
                            if (cfg_q.parity_en) begin
                                state <= T_PARITY;
                                tx <= par_q;
                            end else begin
                                state <= T_STOP;
                                tx <= 1'b1;
                            end
                        end else begin
                            tx <= shift_q[1];
                        end
                    end
                end

                T_PARITY: begin
                    if (bit_end) begin
                        state <= T_STOP;
                        tx <= 1'b1;
                    end
                end

                T_STOP: begin
                    if (bit_end) begin
                        if (cfg_q.two_stop && !stop_cnt) begin
                            stop_cnt <= 1'b1;
                        end else begin
                            state <= T_IDLE;
                        end
                    end
                end

                default: begin
                    state <= T_IDLE;
                    tx <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_rx_frame.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"
`default_nettype none

module uart_rx_frame (
    input  wire logic                 clk_16bd,
    input  wire logic                 rst,
    input  wire logic                 rx,
    input  wire uart_pkg::frame_cfg_t cfg,
    output uart_pkg::rx_result_t      rx_out
);

    localparam int CNT_W = $clog2(`UART_OVERSAMPLE);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`UART_OVERSAMPLE - 1);
    localparam logic [CNT_W-1:0] MID = CNT_W'(`UART_MID_SAMPLE);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP,
        S_DROP
    } rx_state_t;

    rx_state_t state;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    logic [CNT_W-1:0] sample_cnt;
    logic [3:0] bit_cnt;
    logic stop_cnt;
    logic par;
    logic [`UART_DATA_W-1:0] data_q;

    logic fall;
    logic mid;
    logic last_data;
    logic final_stop;

    // two flops against metastability, a third only for edge detect
    always_ff @(posedge clk_16bd or negedge rst) begin
        if (!rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev & ~rx_sync;
    assign mid = (state != S_IDLE) && (sample_cnt == MID);
    assign last_data = (bit_cnt == cfg.data_bits - 4'd1);
    assign final_stop = !cfg.two_stop || stop_cnt;

    always_ff @(posedge clk_16bd or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
            sample_cnt <= '0;
            bit_cnt <= '0;
            stop_cnt <= 1'b0;
            par <= 1'b0;
            data_q <= '0;
            rx_out <= '0;
        end else begin
            rx_out.valid <= 1'b0;
            rx_out.error <= 1'b0;

            // the edge cycle counts as sample 0 of the start bit
            if (state == S_IDLE) begin
                sample_cnt <= CNT_W'(1);
            end else if (sample_cnt == LAST) begin
                sample_cnt <= '0;
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (fall) begin
                        state <= S_START;
                    end
                end

                S_START: begin
                    if (mid) begin
                        if (rx_sync) begin
                            // line back high, just a glitch
                            state <= S_IDLE;
                        end else begin
                            state <= S_DATA;
                            bit_cnt <= '0;
                            par <= 1'b0;
                            data_q <= '0;
                        end
                    end
                end

                S_DATA: begin
                    if (mid) begin
                        data_q[bit_cnt] <= rx_sync;
                        par <= par ^ rx_sync;
                        bit_cnt <= bit_cnt + 4'd1;
                        if (last_data) begin
                            stop_cnt <= 1'b0;
                            state <= cfg.parity_en ? S_PARITY : S_STOP;
                        end
                    end
                end

                S_PARITY: begin
                    // data plus parity must xor to 1 for odd, 0 for even
                    if (mid) begin
                        if ((par ^ rx_sync) == cfg.parity_odd) begin
                            state <= S_STOP;
                        end else begin
                            state <= S_DROP;
                        end
                    end
                end

                S_STOP: begin
                    if (mid) begin
                        if (!rx_sync) begin
                            rx_out.error <= 1'b1;
                            state <= S_IDLE;
                        end else if (final_stop) begin
                            rx_out.valid <= 1'b1;
                            rx_out.data <= data_q;
                            state <= S_IDLE;
                        end else begin
                            stop_cnt <= 1'b1;
                        end
                    end
                end

                // parity already failed, ride out the stop bits
                S_DROP: begin
                    if (mid) begin
                        if (!rx_sync || final_stop) begin
                            rx_out.error <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            stop_cnt <= 1'b1;
                        end
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_link.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"
`default_nettype none

module uart_link (
    input  wire logic                    clk_16bd,
    input  wire logic                    rst,
    input  wire uart_pkg::frame_cfg_t    cfg,
    input  wire logic [`UART_DATA_W-1:0] tx_data,
    input  wire logic                    tx_start,
    output wire logic                    tx,
    output wire logic                    tx_busy,
    input  wire logic                    rx,
    output wire uart_pkg::rx_result_t    rx_out
);

    // tx and rx stay separate lines, loopback is wired outside

    uart_tx_frame u_tx (
        .clk_16bd (clk_16bd),
        .rst      (rst),
        .cfg      (cfg),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_rx_frame u_rx (
        .clk_16bd (clk_16bd),
        .rst      (rst),
        .rx       (rx),
        .cfg      (cfg),
        .rx_out   (rx_out)
    );

endmodule

`default_nettype wire

//--- uart_link_props.sv
`timescale 1ns/10ps
`default_nettype none

module uart_link_props (
    input wire logic                 clk_16bd,
    input wire logic                 rst,
    input wire logic                 tx,
    input wire logic                 tx_busy,
    input wire uart_pkg::rx_result_t rx_out
);

    // a frame ends either good or bad
    a_valid_error_excl: assert property (@(posedge clk_16bd) disable iff (!rst)
        !(rx_out.valid && rx_out.error))
        else $error("rx_out valid and error high in the same cycle");

    a_valid_single: assert property (@(posedge clk_16bd) disable iff (!rst)
        rx_out.valid |=> !rx_out.valid)
        else $error("rx_out valid held longer than one cycle");

    a_error_single: assert property (@(posedge clk_16bd) disable iff (!rst)
        rx_out.error |=> !rx_out.error)
        else $error("rx_out error held longer than one cycle");

    // idle line is high
    a_idle_line: assert property (@(posedge clk_16bd) disable iff (!rst)
        !tx_busy |-> tx)
        else $error("tx low while transmitter idle");

endmodule

bind uart_link uart_link_props u_props (
    .clk_16bd (clk_16bd),
    .rst      (rst),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .rx_out   (rx_out)
);

`default_nettype wire

//--- tb_uart_link.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"
`default_nettype none

module tb_uart_link;

    import uart_pkg::*;

    localparam int BIT_CYC = `UART_OVERSAMPLE;
    localparam int PULSE_TIMEOUT = 24 * `UART_OVERSAMPLE;

    logic clk_16bd;
    logic rst;
    frame_cfg_t cfg;
    logic [`UART_DATA_W-1:0] tx_data;
    logic tx_start;
    logic tx;
    logic tx_busy;
    logic rx;
    rx_result_t rx_out;

    // rx comes from the DUT's own tx or from a line the testbench drives
    logic loopback;
    logic line_drv;

    integer seed;
    int errors = 0;
    int failures = 0;
    int valid_cnt = 0;
    int error_cnt = 0;
    logic [`UART_DATA_W-1:0] last_data;

    assign rx = loopback ? tx : line_drv;

    uart_link DUT (
        .clk_16bd (clk_16bd),
        .rst      (rst),
        .cfg      (cfg),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .rx       (rx),
        .rx_out   (rx_out)
    );

    initial begin
        clk_16bd = 1'b0;
        forever #50 clk_16bd = ~clk_16bd;
    end

    // pulses counted mid-cycle, wait loops read the counts at posedge
    always @(negedge clk_16bd) begin
        if (rx_out.valid) begin
            valid_cnt = valid_cnt + 1;
            last_data = rx_out.data;
        end
        if (rx_out.error) begin
            error_cnt = error_cnt + 1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    function automatic frame_cfg_t rand_cfg();
        frame_cfg_t c;
        c.parity_en = 1'($random(seed));
        c.parity_odd = 1'($random(seed));
        c.two_stop = 1'($random(seed));
        c.data_bits = 4'(5 + ($unsigned($random(seed)) % 5));
        return c;
    endfunction

    function automatic int frame_len(input frame_cfg_t c);
        return 1 + int'(c.data_bits) + int'(c.parity_en) + 1 + int'(c.two_stop);
    endfunction

    function automatic logic [`UART_DATA_W-1:0] masked(input frame_cfg_t c,
                                                       input logic [`UART_DATA_W-1:0] d);
        logic [`UART_DATA_W-1:0] m;
        m = '0;
        for (int i = 0; i < int'(c.data_bits); i++) begin
            m[4'(i)] = d[4'(i)];
        end
        return m;
    endfunction

    // line bits in send order, index 0 is the start bit
    function automatic logic [15:0] frame_bits(input frame_cfg_t c,
                                               input logic [`UART_DATA_W-1:0] d);
        logic [15:0] bits;
        logic par;
        int db;
        bits = '1;
        db = int'(c.data_bits);
        // even parity starts from 0, odd from 1
        par = c.parity_odd;
        bits[0] = 1'b0;
        for (int i = 0; i < db; i++) begin
            bits[4'(1 + i)] = d[4'(i)];
            par = par ^ d[4'(i)];
        end
        if (c.parity_en) begin
            bits[4'(1 + db)] = par;
        end
        return bits;
    endfunction

    task automatic wait_pulse(input string name, input int v0, input int e0);
        int n;
        n = 0;
        while (valid_cnt + error_cnt == v0 + e0 && n < PULSE_TIMEOUT) begin
            @(posedge clk_16bd);
            n++;
        end
        if (valid_cnt + error_cnt == v0 + e0) begin
            $display("%s: receiver gave no valid or error pulse in %0d cycles", name, n);
            failures++;
        end
    endtask

    task automatic loop_frame(input int k);
        frame_cfg_t c;
        logic [`UART_DATA_W-1:0] d;
        logic [15:0] bits;
        int len;
        int cyc;
        int v0;
        int e0;
        c = rand_cfg();
        d = 9'($random(seed));
        bits = frame_bits(c, d);
        len = frame_len(c);
        v0 = valid_cnt;
        e0 = error_cnt;
        @(negedge clk_16bd);
        cfg <= c;
        tx_data <= d;
        tx_start <= 1'b1;
        @(negedge clk_16bd);
        tx_start <= 1'b0;
        // cycle 0 is the first cycle of the start bit
        cyc = 0;
        while (tx_busy && cyc < 16 * BIT_CYC) begin
            if (cyc % BIT_CYC == `UART_MID_SAMPLE && cyc / BIT_CYC < len) begin
                check_val($sformatf("frame %0d tx bit %0d", k, cyc / BIT_CYC),
                          32'(bits[4'(cyc / BIT_CYC)]), 32'(tx));
            end
            cyc++;
            @(negedge clk_16bd);
        end
        if (tx_busy) begin
            $display("frame %0d: tx_busy stayed high past the longest frame", k);
            failures++;
        end
        check_val($sformatf("frame %0d busy cycles", k), 32'(BIT_CYC * len), 32'(cyc));
        wait_pulse($sformatf("frame %0d", k), v0, e0);
        repeat (4) @(negedge clk_16bd);
        check_val($sformatf("frame %0d valid count", k), 1, valid_cnt - v0);
        check_val($sformatf("frame %0d error count", k), 0, error_cnt - e0);
        check_val($sformatf("frame %0d data", k), 32'(masked(c, d)), 32'(last_data));
    endtask

    task automatic drive_frame(input logic [15:0] bits, input int len);
        for (int i = 0; i < len; i++) begin
            line_drv <= bits[4'(i)];
            repeat (BIT_CYC) @(negedge clk_16bd);
        end
        line_drv <= 1'b1;
    endtask

    // flip < 0 sends a clean frame
    task automatic direct_case(input string name, input frame_cfg_t c,
                               input logic [`UART_DATA_W-1:0] d, input int flip,
                               input bit exp_valid);
        logic [15:0] bits;
        int v0;
        int e0;
        bits = frame_bits(c, d);
        if (flip >= 0) begin
            bits[4'(flip)] = ~bits[4'(flip)];
        end
        v0 = valid_cnt;
        e0 = error_cnt;
        @(negedge clk_16bd);
        cfg <= c;
        drive_frame(bits, frame_len(c));
        wait_pulse(name, v0, e0);
        repeat (2 * BIT_CYC) @(negedge clk_16bd);
        check_val({name, " valid count"}, exp_valid ? 1 : 0, valid_cnt - v0);
        check_val({name, " error count"}, exp_valid ? 0 : 1, error_cnt - e0);
        if (exp_valid) begin
            check_val({name, " data"}, 32'(masked(c, d)), 32'(last_data));
        end
    endtask

    initial begin
        frame_cfg_t c;
        int v0;
        int e0;
        seed = 10;
        rst <= 1'b0;
        cfg <= 7'b000_1000;
        tx_data <= '0;
        tx_start <= 1'b0;
        loopback <= 1'b1;
        line_drv <= 1'b1;
        repeat (2) @(posedge clk_16bd);
        @(negedge clk_16bd);
        rst <= 1'b1;

        // reset state, idle line
        @(negedge clk_16bd);
        check_val("reset tx", 1, 32'(tx));
        check_val("reset tx_busy", 0, 32'(tx_busy));
        check_val("reset rx data", 0, 32'(rx_out.data));
        repeat (40) @(negedge clk_16bd);
        check_val("reset valid count", 0, valid_cnt);
        check_val("reset error count", 0, error_cnt);

        // loopback with framing checks
        for (int k = 0; k < 40; k++) begin
            loop_frame(k);
        end

        @(negedge clk_16bd);
        loopback <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            c = rand_cfg();
            c.parity_en = 1'b1;
            direct_case("parity error", c, 9'($random(seed)), 1 + int'(c.data_bits), 1'b0);
            direct_case("after parity error", c, 9'($random(seed)), -1, 1'b1);
        end

        for (int k = 0; k < 3; k++) begin
            c = rand_cfg();
            c.two_stop = 1'b0;
            direct_case("low stop", c, 9'($random(seed)), frame_len(c) - 1, 1'b0);
            c.two_stop = 1'b1;
            direct_case("low first stop", c, 9'($random(seed)), frame_len(c) - 2, 1'b0);
            direct_case("low second stop", c, 9'($random(seed)), frame_len(c) - 1, 1'b0);
            direct_case("after stop error", c, 9'($random(seed)), -1, 1'b1);
        end

        // low pulses of 1 to 7 cycles on an idle line
        for (int g = 1; g < `UART_MID_SAMPLE; g++) begin
            v0 = valid_cnt;
            e0 = error_cnt;
            @(negedge clk_16bd);
            line_drv <= 1'b0;
            repeat (g) @(negedge clk_16bd);
            line_drv <= 1'b1;
            repeat (2 * BIT_CYC) @(negedge clk_16bd);
            check_val($sformatf("glitch %0d valid count", g), 0, valid_cnt - v0);
            check_val($sformatf("glitch %0d error count", g), 0, error_cnt - e0);
            direct_case("after glitch", rand_cfg(), 9'($random(seed)), -1, 1'b1);
        end

        $display("closing: %0d value errors, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
uart_pkg.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_link.sv
uart_link_props.sv
tb_uart_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the uart link testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f files.f --top-module tb_uart_link -o sim_uart_link > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_uart_link > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$SIM_LOG"; then
    exit 1
fi
exit 0
